/* simd_pkg.sv */
/* Shared widths, encodings and latencies of the 128-bit SIMD execution unit.
 * Every RTL file refers to these by scoped name.
 */
package simd_pkg;

    // Datapath geometry
    localparam int VLEN    = 128;
    localparam int LANE_W  = 64;
    localparam int N_LANES = VLEN / LANE_W;
    localparam int MASK_W  = VLEN / 8;        // One bit per byte-sized element
    localparam int VL_W    = 5;               // Holds 0 to 16
    localparam int TAG_W   = 4;
    localparam int IMM_W   = 5;

    // Cycles from issue to result
    localparam int ALU_LAT   = 1;
    localparam int MUL_LAT   = 2;             // SEW_8 to SEW_32
    localparam int MUL64_LAT = 3;
    localparam int MAX_LAT   = 3;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_e;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,       // Low half of the product
        OP_MSEQ,
        OP_MSLT,      // Signed vs2 < vs1
        OP_MV_X_S,    // Element 0 to scalar, sign extended
        OP_EXT        // Element rs1 to scalar, zero extended
    } simd_op_e;

    // Source of the first operand
    typedef enum logic [1:0] {
        SRC_VV,
        SRC_VX,
        SRC_VI
    } src_e;

endpackage

/* operand_prep.sv */
/* First-operand selection for the SIMD lanes. A scalar register or a
 * sign-extended immediate is replicated across the vector at the element
 * width; vector-vector ops pass vs1 through unchanged.
 */
`timescale 1ns/1ps

module operand_prep (
    input  simd_pkg::sew_e              sew_i,
    input  simd_pkg::src_e              src_i,
    input  logic [simd_pkg::VLEN-1:0]   vs1_i,
    input  logic [simd_pkg::LANE_W-1:0] rs1_i,
    input  logic [simd_pkg::IMM_W-1:0]  imm_i,
    output logic [simd_pkg::VLEN-1:0]   opa_o
);

    logic [simd_pkg::LANE_W-1:0] scalar;
    logic [simd_pkg::VLEN-1:0]   splat;

    // Immediate is sign extended to the full lane, so any low slice is the
    // sign-extended value at that element width
    always_comb begin
        if (src_i == simd_pkg::SRC_VI) begin
            scalar = $signed(imm_i);
        end else begin
            scalar = rs1_i;
        end
    end

    always_comb begin
        case (sew_i)
            simd_pkg::SEW_8: begin
                splat = {(simd_pkg::VLEN/8){scalar[7:0]}};
            end
            simd_pkg::SEW_16: begin
                splat = {(simd_pkg::VLEN/16){scalar[15:0]}};
            end
            simd_pkg::SEW_32: begin
                splat = {(simd_pkg::VLEN/32){scalar[31:0]}};
            end
            default: begin
                splat = {(simd_pkg::VLEN/64){scalar}};
            end
        endcase
    end

    assign opa_o = (src_i == simd_pkg::SRC_VV) ? vs1_i : splat;

endmodule

/* lane_alu.sv */
/* Arithmetic, logic, multiply and compare datapath of one 64-bit lane.
 * Combinational. All four element widths are computed side by side and
 * sew_i picks the one that is driven out. opa is vs1, opb is vs2.
 */
`timescale 1ns/1ps

module lane_alu (
    input  simd_pkg::simd_op_e             op_i,
    input  simd_pkg::sew_e                 sew_i,
    input  logic [simd_pkg::LANE_W-1:0]    opa_i,
    input  logic [simd_pkg::LANE_W-1:0]    opb_i,
    output logic [simd_pkg::LANE_W-1:0]    res_o,
    output logic [simd_pkg::LANE_W/8-1:0]  cmp_o
);

    // One candidate per element width, indexed by sew
    logic [simd_pkg::LANE_W-1:0]   res_w [4];
    logic [simd_pkg::LANE_W/8-1:0] cmp_w [4];

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int EW = 8 << s;                   // Element width in bits
        localparam int NE = simd_pkg::LANE_W / EW;    // Elements in this lane

        always_comb begin
            logic signed [simd_pkg::LANE_W-1:0] a;
            logic signed [simd_pkg::LANE_W-1:0] b;
            logic [simd_pkg::LANE_W-1:0]        r;
            res_w[s] = '0;
            cmp_w[s] = '0;      // Bits above the element count stay zero
            for (int j = 0; j < NE; j++) begin
                // Sign extension keeps the low bits of add, sub and mul exact
                // and lets the signed compare work on the full lane
                a = $signed(opa_i[j*EW +: EW]);
                b = $signed(opb_i[j*EW +: EW]);
                r = '0;
                case (op_i)
                    simd_pkg::OP_ADD: begin
                        r = b + a;
                    end
                    simd_pkg::OP_SUB: begin
                        r = b - a;              // vs2 - vs1
                    end
                    simd_pkg::OP_AND: begin
                        r = b & a;
                    end
                    simd_pkg::OP_OR: begin
                        r = b | a;
                    end
                    simd_pkg::OP_XOR: begin
                        r = b ^ a;
                    end
                    simd_pkg::OP_MUL: begin
                        r = b * a;              // Wraps to the element width below
                    end
                    simd_pkg::OP_MSEQ: begin
                        cmp_w[s][j] = (b == a);
                    end
                    simd_pkg::OP_MSLT: begin
                        cmp_w[s][j] = (b < a);
                    end
                    default: begin
                        r = '0;                 // Scalar moves read vs2 downstream
                    end
                endcase
                res_w[s][j*EW +: EW] = r[EW-1:0];
            end
        end
    end

    assign res_o = res_w[sew_i];
    assign cmp_o = cmp_w[sew_i];

endmodule

/* latency_pipe.sv */
/* Latency tracking for the SIMD unit. One delay chain per latency, 1 to
 * MAX_LAT slots long. An issued instruction enters the chain that matches
 * its latency together with its computed results; the longest chain that
 * completes in a cycle owns the output, a shorter one finishing then is lost.
 */
`timescale 1ns/1ps

module latency_pipe (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          valid_i,
    input  logic [simd_pkg::TAG_W-1:0]    tag_i,
    input  simd_pkg::simd_op_e            op_i,
    input  simd_pkg::sew_e                sew_i,
    input  logic                          use_mask_i,
    input  logic [simd_pkg::MASK_W-1:0]   vm_i,
    input  logic [simd_pkg::VL_W-1:0]     vl_i,
    input  logic [simd_pkg::VLEN-1:0]     old_vd_i,
    input  logic [simd_pkg::VLEN-1:0]     vs2_i,
    input  logic [simd_pkg::LANE_W-1:0]   rs1_i,
    input  logic [simd_pkg::VLEN-1:0]     lane_res_i,
    input  logic [simd_pkg::MASK_W-1:0]   cmp_i,
    output logic                          done_o,
    output logic [simd_pkg::TAG_W-1:0]    tag_o,
    output simd_pkg::simd_op_e            op_o,
    output simd_pkg::sew_e                sew_o,
    output logic                          use_mask_o,
    output logic [simd_pkg::MASK_W-1:0]   vm_o,
    output logic [simd_pkg::VL_W-1:0]     vl_o,
    output logic [simd_pkg::VLEN-1:0]     old_vd_o,
    output logic [simd_pkg::VLEN-1:0]     vs2_o,
    output logic [simd_pkg::LANE_W-1:0]   rs1_o,
    output logic [simd_pkg::VLEN-1:0]     lane_res_o,
    output logic [simd_pkg::MASK_W-1:0]   cmp_o
);

    localparam int OP_W  = $bits(simd_pkg::simd_op_e);
    localparam int SEW_W = $bits(simd_pkg::sew_e);
    localparam int PAY_W = simd_pkg::TAG_W + OP_W + SEW_W + 1 + 2 * simd_pkg::MASK_W
                         + simd_pkg::VL_W + 3 * simd_pkg::VLEN + simd_pkg::LANE_W;
    localparam int LAT_W = $clog2(simd_pkg::MAX_LAT + 1);

    logic [LAT_W-1:0] lat;
    logic [PAY_W-1:0] pay_in;
    logic [PAY_W-1:0] pay_out;
    logic [OP_W-1:0]  op_bits;
    logic [SEW_W-1:0] sew_bits;
    logic [simd_pkg::MAX_LAT:1] last_vld;               // Last slot of each chain
    logic [PAY_W-1:0]           last_pay [1:simd_pkg::MAX_LAT];

    always_comb begin
        if (op_i == simd_pkg::OP_MUL) begin
            lat = (sew_i == simd_pkg::SEW_64) ? LAT_W'(simd_pkg::MUL64_LAT)
                                              : LAT_W'(simd_pkg::MUL_LAT);
        end else begin
            lat = LAT_W'(simd_pkg::ALU_LAT);
        end
    end

    assign pay_in = {tag_i, op_i, sew_i, use_mask_i, vm_i, vl_i,
                     old_vd_i, vs2_i, rs1_i, lane_res_i, cmp_i};

    for (genvar c = 1; c <= simd_pkg::MAX_LAT; c++) begin : g_chain
        logic             load;
        logic [c-1:0]     vld_q;
        logic [PAY_W-1:0] pay_q [c];

        assign load = valid_i && (lat == LAT_W'(c));

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= load;
                for (int j = 1; j < c; j++) begin
                    vld_q[j] <= vld_q[j-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (load) begin
                pay_q[0] <= pay_in;
            end
            for (int j = 1; j < c; j++) begin
                pay_q[j] <= pay_q[j-1];
            end
        end

        assign last_vld[c] = vld_q[c-1];
        assign last_pay[c] = pay_q[c-1];
    end

    // Later iterations overwrite, so the longest chain wins
    always_comb begin
        done_o  = 1'b0;
        pay_out = last_pay[1];
        for (int c = 1; c <= simd_pkg::MAX_LAT; c++) begin
            if (last_vld[c]) begin
                done_o  = 1'b1;
                pay_out = last_pay[c];
            end
        end
    end

    assign {tag_o, op_bits, sew_bits, use_mask_o, vm_o, vl_o,
            old_vd_o, vs2_o, rs1_o, lane_res_o, cmp_o} = pay_out;
    assign op_o  = simd_pkg::simd_op_e'(op_bits);
    assign sew_o = simd_pkg::sew_e'(sew_bits);

endmodule

/* result_pack.sv */
/* Write-back formatting for the SIMD unit. Combinational on the completing
 * payload of the latency pipe: packs compare bits into a mask, extracts
 * scalar results, merges masked-off elements from old vd and fills the tail.
 */
`timescale 1ns/1ps

module result_pack (
    input  logic                          done_i,
    input  simd_pkg::simd_op_e            op_i,
    input  simd_pkg::sew_e                sew_i,
    input  logic [simd_pkg::TAG_W-1:0]    tag_i,
    input  logic                          use_mask_i,
    input  logic [simd_pkg::MASK_W-1:0]   vm_i,
    input  logic [simd_pkg::VL_W-1:0]     vl_i,
    input  logic [simd_pkg::VLEN-1:0]     old_vd_i,
    input  logic [simd_pkg::VLEN-1:0]     vs2_i,
    input  logic [simd_pkg::LANE_W-1:0]   rs1_i,
    input  logic [simd_pkg::VLEN-1:0]     lane_res_i,
    input  logic [simd_pkg::MASK_W-1:0]   cmp_i,
    output logic                          vd_valid_o,
    output logic [simd_pkg::TAG_W-1:0]    vd_tag_o,
    output logic [simd_pkg::VLEN-1:0]     vd_o,
    output logic                          rd_valid_o,
    output logic [simd_pkg::TAG_W-1:0]    rd_tag_o,
    output logic [simd_pkg::LANE_W-1:0]   rd_o
);

    logic                          is_cmp;
    logic                          is_scalar;
    int unsigned                   n_elem;      // Elements in the vector
    int unsigned                   lane_elem;   // Elements per lane
    logic [simd_pkg::MASK_W-1:0]   cmp_bits;
    logic [simd_pkg::VLEN-1:0]     vec_res;
    logic [simd_pkg::VLEN-1:0]     cmp_res;
    logic [simd_pkg::LANE_W-1:0]   mv_res;
    logic [simd_pkg::LANE_W-1:0]   ext_res;

    assign is_cmp    = (op_i == simd_pkg::OP_MSEQ) || (op_i == simd_pkg::OP_MSLT);
    assign is_scalar = (op_i == simd_pkg::OP_MV_X_S) || (op_i == simd_pkg::OP_EXT);
    assign n_elem    = simd_pkg::MASK_W >> sew_i;
    assign lane_elem = n_elem / simd_pkg::N_LANES;

    // Lane L bit j becomes mask bit L*lane_elem + j
    always_comb begin
        cmp_bits = '1;
        for (int l = 0; l < simd_pkg::N_LANES; l++) begin
            for (int j = 0; j < simd_pkg::LANE_W/8; j++) begin
                if (j < lane_elem) begin
                    cmp_bits[l*lane_elem + j] = cmp_i[l*(simd_pkg::LANE_W/8) + j];
                end
            end
        end
    end

    // Byte-wise merge, element index of byte b is b >> sew
    always_comb begin
        int unsigned e;
        for (int b = 0; b < simd_pkg::VLEN/8; b++) begin
            e = b >> sew_i;
            if (e >= vl_i) begin
                vec_res[b*8 +: 8] = '1;                         // Tail
            end else if (use_mask_i && !vm_i[e]) begin
                vec_res[b*8 +: 8] = old_vd_i[b*8 +: 8];
            end else begin
                vec_res[b*8 +: 8] = lane_res_i[b*8 +: 8];
            end
        end
    end

    // Mask result, everything past the element count or vl reads as one
    always_comb begin
        cmp_res = '1;
        for (int i = 0; i < simd_pkg::MASK_W; i++) begin
            if ((i < n_elem) && (i < vl_i)) begin
                cmp_res[i] = (use_mask_i && !vm_i[i]) ? old_vd_i[i] : cmp_bits[i];
            end
        end
    end

    always_comb begin
        case (sew_i)
            simd_pkg::SEW_8:  mv_res = $signed(vs2_i[7:0]);
            simd_pkg::SEW_16: mv_res = $signed(vs2_i[15:0]);
            simd_pkg::SEW_32: mv_res = $signed(vs2_i[31:0]);
            default:          mv_res = vs2_i[simd_pkg::LANE_W-1:0];
        endcase
    end

    always_comb begin
        logic [simd_pkg::VLEN-1:0] shifted;
        shifted = vs2_i >> (rs1_i[$clog2(simd_pkg::MASK_W)-1:0] * (8 << sew_i));
        case (sew_i)
            simd_pkg::SEW_8:  ext_res = shifted[7:0];
            simd_pkg::SEW_16: ext_res = shifted[15:0];
            simd_pkg::SEW_32: ext_res = shifted[31:0];
            default:          ext_res = shifted[simd_pkg::LANE_W-1:0];
        endcase
        if (rs1_i >= n_elem) begin
            ext_res = '0;                                       // Index out of range
        end
    end

    assign vd_valid_o = done_i && !is_scalar;
    assign vd_tag_o   = tag_i;
    assign vd_o       = is_cmp ? cmp_res : vec_res;
    assign rd_valid_o = done_i && is_scalar;
    assign rd_tag_o   = tag_i;
    assign rd_o       = (op_i == simd_pkg::OP_MV_X_S) ? mv_res : ext_res;

endmodule

/* simd_unit.sv */
/* Top level of the two-lane SIMD execution unit. Operands are prepared and
 * computed in the issue cycle, delayed by the latency pipe and formatted
 * into vector or scalar write-back pulses.
 */
`timescale 1ns/1ps

module simd_unit (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          valid_i,
    input  logic [simd_pkg::TAG_W-1:0]    tag_i,
    input  simd_pkg::simd_op_e            op_i,
    input  simd_pkg::sew_e                sew_i,
    input  simd_pkg::src_e                src_i,
    input  logic [simd_pkg::VLEN-1:0]     vs1_i,
    input  logic [simd_pkg::VLEN-1:0]     vs2_i,
    input  logic [simd_pkg::VLEN-1:0]     old_vd_i,
    input  logic [simd_pkg::LANE_W-1:0]   rs1_i,
    input  logic [simd_pkg::IMM_W-1:0]    imm_i,
    input  logic [simd_pkg::MASK_W-1:0]   vm_i,
    input  logic                          use_mask_i,
    input  logic [simd_pkg::VL_W-1:0]     vl_i,
    output logic                          vd_valid_o,
    output logic [simd_pkg::TAG_W-1:0]    vd_tag_o,
    output logic [simd_pkg::VLEN-1:0]     vd_o,
    output logic                          rd_valid_o,
    output logic [simd_pkg::TAG_W-1:0]    rd_tag_o,
    output logic [simd_pkg::LANE_W-1:0]   rd_o
);

    localparam int CMP_W = simd_pkg::LANE_W / 8;

    logic [simd_pkg::VLEN-1:0]   opa;
    logic [simd_pkg::VLEN-1:0]   lane_res;
    logic [simd_pkg::MASK_W-1:0] lane_cmp;

    // Completing payload
    logic                        p_done;
    logic [simd_pkg::TAG_W-1:0]  p_tag;
    simd_pkg::simd_op_e          p_op;
    simd_pkg::sew_e              p_sew;
    logic                        p_use_mask;
    logic [simd_pkg::MASK_W-1:0] p_vm;
    logic [simd_pkg::VL_W-1:0]   p_vl;
    logic [simd_pkg::VLEN-1:0]   p_old_vd;
    logic [simd_pkg::VLEN-1:0]   p_vs2;
    logic [simd_pkg::LANE_W-1:0] p_rs1;
    logic [simd_pkg::VLEN-1:0]   p_lane_res;
    logic [simd_pkg::MASK_W-1:0] p_cmp;

    operand_prep u_operand_prep (
        .sew_i (sew_i),
        .src_i (src_i),
        .vs1_i (vs1_i),
        .rs1_i (rs1_i),
        .imm_i (imm_i),
        .opa_o (opa)
    );

    for (genvar l = 0; l < simd_pkg::N_LANES; l++) begin : g_lane
        lane_alu u_lane_alu (
            .op_i  (op_i),
            .sew_i (sew_i),
            .opa_i (opa[l*simd_pkg::LANE_W +: simd_pkg::LANE_W]),
            .opb_i (vs2_i[l*simd_pkg::LANE_W +: simd_pkg::LANE_W]),
            .res_o (lane_res[l*simd_pkg::LANE_W +: simd_pkg::LANE_W]),
            .cmp_o (lane_cmp[l*CMP_W +: CMP_W])
        );
    end

    latency_pipe u_latency_pipe (
        .clk_i      (clk_i),      .rstn_i     (rstn_i),
        .valid_i    (valid_i),    .tag_i      (tag_i),
        .op_i       (op_i),       .sew_i      (sew_i),
        .use_mask_i (use_mask_i), .vm_i       (vm_i),
        .vl_i       (vl_i),       .old_vd_i   (old_vd_i),
        .vs2_i      (vs2_i),      .rs1_i      (rs1_i),
        .lane_res_i (lane_res),   .cmp_i      (lane_cmp),
        .done_o     (p_done),     .tag_o      (p_tag),
        .op_o       (p_op),       .sew_o      (p_sew),
        .use_mask_o (p_use_mask), .vm_o       (p_vm),
        .vl_o       (p_vl),       .old_vd_o   (p_old_vd),
        .vs2_o      (p_vs2),      .rs1_o      (p_rs1),
        .lane_res_o (p_lane_res), .cmp_o      (p_cmp)
    );

    result_pack u_result_pack (
        .done_i     (p_done),     .op_i       (p_op),
        .sew_i      (p_sew),      .tag_i      (p_tag),
        .use_mask_i (p_use_mask), .vm_i       (p_vm),
        .vl_i       (p_vl),       .old_vd_i   (p_old_vd),
        .vs2_i      (p_vs2),      .rs1_i      (p_rs1),
        .lane_res_i (p_lane_res), .cmp_i      (p_cmp),
        .vd_valid_o (vd_valid_o), .vd_tag_o   (vd_tag_o),
        .vd_o       (vd_o),       .rd_valid_o (rd_valid_o),
        .rd_tag_o   (rd_tag_o),   .rd_o       (rd_o)
    );

endmodule

/* simd_unit_tb.sv */
/* Directed testbench for the two-lane SIMD unit. Each test issues instructions
 * on the falling clock edge and checks vd or rd write-back against a
 * behavioural model of the element rules.
 */
`timescale 1ns/1ps

module simd_unit_tb;

    localparam int TIMEOUT = 8;

    logic                        clk_i, rstn_i, valid_i, use_mask_i;
    logic [simd_pkg::TAG_W-1:0]  tag_i;
    simd_pkg::simd_op_e          op_i;
    simd_pkg::sew_e              sew_i;
    simd_pkg::src_e              src_i;
    logic [simd_pkg::VLEN-1:0]   vs1_i, vs2_i, old_vd_i;
    logic [simd_pkg::LANE_W-1:0] rs1_i;
    logic [simd_pkg::IMM_W-1:0]  imm_i;
    logic [simd_pkg::MASK_W-1:0] vm_i;
    logic [simd_pkg::VL_W-1:0]   vl_i;
    logic                        vd_valid_o, rd_valid_o;
    logic [simd_pkg::TAG_W-1:0]  vd_tag_o, rd_tag_o;
    logic [simd_pkg::VLEN-1:0]   vd_o;
    logic [simd_pkg::LANE_W-1:0] rd_o;

    integer seed = 93;
    int     n_pass, n_fail, fails_at_start;
    string  test_name;
    logic [simd_pkg::TAG_W-1:0] next_tag;

    simd_unit u_simd_unit (
        .clk_i      (clk_i),      .rstn_i     (rstn_i),     .valid_i    (valid_i),
        .tag_i      (tag_i),      .op_i       (op_i),       .sew_i      (sew_i),
        .src_i      (src_i),      .vs1_i      (vs1_i),      .vs2_i      (vs2_i),
        .old_vd_i   (old_vd_i),   .rs1_i      (rs1_i),      .imm_i      (imm_i),
        .vm_i       (vm_i),       .use_mask_i (use_mask_i), .vl_i       (vl_i),
        .vd_valid_o (vd_valid_o), .vd_tag_o   (vd_tag_o),   .vd_o       (vd_o),
        .rd_valid_o (rd_valid_o), .rd_tag_o   (rd_tag_o),   .rd_o       (rd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [63:0] elem_mask(input int ew);
        return (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
    endfunction

    function automatic logic [63:0] sign_ext(input logic [63:0] x, input int ew);
        logic [63:0] m;
        m = elem_mask(ew);
        x = x & m;
        if (x[ew-1]) begin
            x = x | ~m;
        end
        return x;
    endfunction

    function automatic logic [63:0] elem(input logic [127:0] v, input int idx, input int ew);
        return (v >> (idx * ew)) & elem_mask(ew);
    endfunction

    // Element-wise model of a vector result, read from the inputs being issued
    function automatic logic [127:0] model_vector();
        int           ew;
        int           n;
        logic [63:0]  m, a, b, r;
        logic [127:0] res;
        logic         cmp;
        ew  = 8 << sew_i;
        n   = 16 >> sew_i;
        m   = elem_mask(ew);
        res = '1;                                   // Tail and unused mask bits
        for (int j = 0; j < n; j++) begin
            b = elem(vs2_i, j, ew);
            case (src_i)
                simd_pkg::SRC_VV: a = elem(vs1_i, j, ew);
                simd_pkg::SRC_VX: a = rs1_i & m;
                default:          a = sign_ext(64'(imm_i), simd_pkg::IMM_W) & m;
            endcase
            case (op_i)
                simd_pkg::OP_ADD: r = b + a;
                simd_pkg::OP_SUB: r = b - a;
                simd_pkg::OP_AND: r = b & a;
                simd_pkg::OP_OR:  r = b | a;
                simd_pkg::OP_XOR: r = b ^ a;
                simd_pkg::OP_MUL: r = b * a;
                default:          r = '0;
            endcase
            if (op_i == simd_pkg::OP_MSEQ) begin
                cmp = (a == b);
            end else begin
                cmp = $signed(sign_ext(b, ew)) < $signed(sign_ext(a, ew));
            end
            if (j < vl_i) begin
                if (use_mask_i && !vm_i[j]) begin
                    r   = elem(old_vd_i, j, ew);
                    cmp = old_vd_i[j];
                end
                if (op_i == simd_pkg::OP_MSEQ || op_i == simd_pkg::OP_MSLT) begin
                    res[j] = cmp;
                end else begin
                    res = res & ~({64'd0, m} << (j * ew));
                    res = res | ({64'd0, r & m} << (j * ew));
                end
            end
        end
        return res;
    endfunction

    function automatic logic [63:0] model_scalar();
        int ew;
        ew = 8 << sew_i;
        if (op_i == simd_pkg::OP_MV_X_S) begin
            return sign_ext(elem(vs2_i, 0, ew), ew);
        end else if (rs1_i >= (16 >> sew_i)) begin
            return '0;
        end
        return elem(vs2_i, int'(rs1_i), ew);
    endfunction

    task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        fails_at_start = n_fail;
    endtask

    task automatic end_test();
        if (n_fail == fails_at_start) begin
            $display("Test %s: ok", test_name);
        end else begin
            $display("Test %s: %0d errors", test_name, n_fail - fails_at_start);
        end
    endtask

    // Drive one instruction with random operands; valid stays high until finish
    task automatic drive_instr(input simd_pkg::simd_op_e op, input simd_pkg::sew_e sew,
                               input simd_pkg::src_e src, input bit use_mask, input int vl);
        @(negedge clk_i);
        valid_i    = 1'b1;
        tag_i      = next_tag;
        next_tag   = next_tag + 1'b1;
        op_i       = op;
        sew_i      = sew;
        src_i      = src;
        use_mask_i = use_mask;
        vl_i       = vl;
        vs1_i      = {$random(seed), $random(seed), $random(seed), $random(seed)};
        vs2_i      = {$random(seed), $random(seed), $random(seed), $random(seed)};
        old_vd_i   = {$random(seed), $random(seed), $random(seed), $random(seed)};
        rs1_i      = {$random(seed), $random(seed)};
        imm_i      = $random(seed);
        vm_i       = $random(seed);
    endtask

    task automatic wait_result(input bit scalar, output int cycles);
        cycles = 1;
        while (!(scalar ? rd_valid_o : vd_valid_o) && cycles <= TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!(scalar ? rd_valid_o : vd_valid_o)) begin
            $display("Timeout in %s: no result appeared within %0d cycles", test_name, TIMEOUT);
            n_fail++;
        end
    endtask

    task automatic run_vector(input int lat);
        logic [127:0] exp;
        logic [3:0]   tag;
        int           cycles;
        exp = model_vector();
        tag = tag_i;
        @(negedge clk_i);
        valid_i = 1'b0;
        wait_result(1'b0, cycles);
        check("latency", lat, cycles);
        check("tag", tag, vd_tag_o);
        check("vd", exp, vd_o);
        check("rd_valid", 0, rd_valid_o);
    endtask

    task automatic run_scalar();
        logic [63:0] exp;
        logic [3:0]  tag;
        int          cycles;
        exp = model_scalar();
        tag = tag_i;
        @(negedge clk_i);
        valid_i = 1'b0;
        wait_result(1'b1, cycles);
        check("latency", 1, cycles);
        check("tag", tag, rd_tag_o);
        check("rd", exp, rd_o);
        check("vd_valid", 0, vd_valid_o);
    endtask

    task automatic test_reset();
        begin_test("reset");
        for (int c = 0; c < 4; c++) begin
            @(negedge clk_i);
            check("vd_valid", 0, vd_valid_o);
            check("rd_valid", 0, rd_valid_o);
            valid_i = (c == 2);                     // Issued while in reset
        end
        rstn_i = 1'b1;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk_i);
            check("vd_valid", 0, vd_valid_o);
            check("rd_valid", 0, rd_valid_o);
        end
        end_test();
    endtask

    task automatic test_alu();
        simd_pkg::simd_op_e ops [5] = '{simd_pkg::OP_ADD, simd_pkg::OP_SUB,
                                        simd_pkg::OP_AND, simd_pkg::OP_OR, simd_pkg::OP_XOR};
        begin_test("alu");
        foreach (ops[i]) begin
            for (int s = 0; s < 4; s++) begin
                for (int k = 0; k < 3; k++) begin
                    drive_instr(ops[i], simd_pkg::sew_e'(s), simd_pkg::src_e'(k), 1'b0, 16 >> s);
                    run_vector(1);
                end
            end
        end
        end_test();
    endtask

    task automatic test_mul();
        logic [127:0] exp_mul;
        logic [3:0]   tag_mul;
        int           cycles;
        begin_test("mul");
        for (int s = 0; s < 4; s++) begin
            if (s != 1) begin
                drive_instr(simd_pkg::OP_MUL, simd_pkg::sew_e'(s), simd_pkg::SRC_VV, 1'b0, 16 >> s);
                run_vector((s == 3) ? 3 : 2);
            end
        end
        // 64-bit multiply followed by an add, which overtakes it
        drive_instr(simd_pkg::OP_MUL, simd_pkg::SEW_64, simd_pkg::SRC_VV, 1'b0, 2);
        exp_mul = model_vector();
        tag_mul = tag_i;
        drive_instr(simd_pkg::OP_ADD, simd_pkg::SEW_64, simd_pkg::SRC_VX, 1'b0, 2);
        run_vector(1);
        @(negedge clk_i);
        wait_result(1'b0, cycles);
        check("mul after add", 1, cycles);
        check("mul tag", tag_mul, vd_tag_o);
        check("mul vd", exp_mul, vd_o);
        end_test();
    endtask

    task automatic test_compare();
        begin_test("compare");
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 3; k++) begin
                drive_instr(simd_pkg::OP_MSEQ, simd_pkg::sew_e'(s), simd_pkg::src_e'(k), 1'b0, 16 >> s);
                vs1_i[63:0] = vs2_i[63:0];          // Lane 0 compares equal
                run_vector(1);
                drive_instr(simd_pkg::OP_MSLT, simd_pkg::sew_e'(s), simd_pkg::src_e'(k), 1'b0, 16 >> s);
                run_vector(1);
            end
        end
        end_test();
    endtask

    task automatic test_mask_tail();
        begin_test("mask_tail");
        for (int s = 0; s < 4; s++) begin
            for (int r = 0; r < 3; r++) begin
                drive_instr(simd_pkg::OP_ADD, simd_pkg::sew_e'(s), simd_pkg::SRC_VX, 1'b1,
                            $unsigned($random(seed)) % (16 >> s));
                run_vector(1);
                drive_instr(simd_pkg::OP_MSEQ, simd_pkg::sew_e'(s), simd_pkg::SRC_VV, 1'b1,
                            $unsigned($random(seed)) % (16 >> s));
                vs1_i[63:0] = vs2_i[63:0];
                run_vector(1);
            end
        end
        end_test();
    endtask

    task automatic test_scalar();
        begin_test("scalar");
        for (int s = 0; s < 4; s++) begin
            drive_instr(simd_pkg::OP_MV_X_S, simd_pkg::sew_e'(s), simd_pkg::SRC_VV, 1'b0, 16 >> s);
            run_scalar();
            drive_instr(simd_pkg::OP_EXT, simd_pkg::sew_e'(s), simd_pkg::SRC_VV, 1'b0, 16 >> s);
            rs1_i = $unsigned($random(seed)) % (16 >> s);
            run_scalar();
            drive_instr(simd_pkg::OP_EXT, simd_pkg::sew_e'(s), simd_pkg::SRC_VV, 1'b0, 16 >> s);
            rs1_i = 16 >> s;                        // First index out of range
            run_scalar();
        end
        end_test();
    endtask

    initial begin
        rstn_i     = 1'b0;
        valid_i    = 1'b0;
        tag_i      = '0;
        op_i       = simd_pkg::OP_ADD;
        sew_i      = simd_pkg::SEW_8;
        src_i      = simd_pkg::SRC_VV;
        vs1_i      = '0;
        vs2_i      = '0;
        old_vd_i   = '0;
        rs1_i      = '0;
        imm_i      = '0;
        vm_i       = '0;
        use_mask_i = 1'b0;
        vl_i       = '0;
        next_tag   = '0;
        n_pass     = 0;
        n_fail     = 0;
        test_reset();
        test_alu();
        test_mul();
        test_compare();
        test_mask_tail();
        test_scalar();
        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
simd_pkg.sv
operand_prep.sv
lane_alu.sv
latency_pipe.sv
result_pack.sv
simd_unit.sv
simd_unit_tb.sv

/* Bender.yml */
package:
  name: simd_unit

sources:
  - simd_pkg.sv
  - operand_prep.sv
  - lane_alu.sv
  - latency_pipe.sv
  - result_pack.sv
  - simd_unit.sv
  - target: test
    files:
      - simd_unit_tb.sv
